// ==== Makefile ====
# Verilator build and run of the correlator testbench

VERILATOR ?= verilator
TOP       ?= tb_corr_top
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: sim clean

# The run passes only if the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== hw/corr_accum.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "corr_settings.svh"

module corr_accum (
    input  logic                                         clk_x,
    input  logic                                         rst_n_i,
    input  logic                                         valid_i,
    input  logic        [`CORR_SLOT_W-1:0]               slot_i,
    input  logic        [`CORR_BANK_W-1:0]               bank_i,
    input  logic signed [`CORR_LANES-1:0][`CORR_PROD_W-1:0] prod_re_i,
    input  logic signed [`CORR_LANES-1:0][`CORR_PROD_W-1:0] prod_im_i,
    input  logic                                         fresh_bank_i,
    input  logic        [`CORR_BANK_W-1:0]               fresh_bank_sel_i,
    input  logic                                         read_ce_i,
    input  logic        [`CORR_ADDR_BITS-1:0]            read_addr_i,
    output logic        [`CORR_ACCUM-1:0]                read_data_o
);

    localparam int words = `CORR_BANKS * `CORR_SLOTS;
    localparam int aw    = `CORR_BANK_W + `CORR_SLOT_W;

    logic signed [`CORR_ACCUM-1:0] mem_re_q [`CORR_LANES][words];
    logic signed [`CORR_ACCUM-1:0] mem_im_q [`CORR_LANES][words];
    logic [`CORR_BANKS-1:0][`CORR_PAIRS-1:0] clr_q;    // Per bank and pair

    logic [aw-1:0]                 rmw_addr;
    logic signed [`CORR_ACCUM-1:0] sum_re [`CORR_LANES];
    logic signed [`CORR_ACCUM-1:0] sum_im [`CORR_LANES];
    logic                          wr_en_q;
    logic [aw-1:0]                 wr_addr_q;
    logic signed [`CORR_ACCUM-1:0] wr_re_q [`CORR_LANES];
    logic signed [`CORR_ACCUM-1:0] wr_im_q [`CORR_LANES];

    logic [`CORR_BANK_W-1:0]       rd_bank;
    logic [`CORR_SLOT_W-1:0]       rd_slot;
    logic [`CORR_LANE_W-1:0]       rd_lane;
    corr_pkg::part_e               rd_part;
    logic [`CORR_ACCUM-1:0]        rd_word_q;
    logic                          rd_vld_q;

    // ------------------------------------------------------------------
    // Read stage of the read-modify-write
    // ------------------------------------------------------------------
    assign rmw_addr = {bank_i, slot_i};

    always_comb begin
        for (int l = 0; l < `CORR_LANES; l++) begin
            if (clr_q[bank_i][slot_i * `CORR_LANES + l]) begin
                sum_re[l] = `CORR_ACCUM'(signed'(prod_re_i[l]));  // Onto zero
                sum_im[l] = `CORR_ACCUM'(signed'(prod_im_i[l]));
            end else begin
                sum_re[l] = mem_re_q[l][rmw_addr] + `CORR_ACCUM'(signed'(prod_re_i[l]));
                sum_im[l] = mem_im_q[l][rmw_addr] + `CORR_ACCUM'(signed'(prod_im_i[l]));
            end
        end
    end

    always_ff @(posedge clk_x or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_en_q <= 1'b0;
        end else begin
            wr_en_q <= valid_i;
        end
    end

    always_ff @(posedge clk_x) begin
        wr_addr_q <= rmw_addr;
        wr_re_q   <= sum_re;
        wr_im_q   <= sum_im;
    end

    // Write stage, one cycle after the read
    always_ff @(posedge clk_x) begin
        if (wr_en_q) begin
            for (int l = 0; l < `CORR_LANES; l++) begin
                mem_re_q[l][wr_addr_q] <= wr_re_q[l];
                mem_im_q[l][wr_addr_q] <= wr_im_q[l];
            end
        end
    end

    // Clear flags; a fresh bank never collides with an in-flight access
    always_ff @(posedge clk_x or negedge rst_n_i) begin
        if (!rst_n_i) begin
            clr_q <= '1;
        end else begin
            if (valid_i) begin
                clr_q[bank_i][slot_i * `CORR_LANES +: `CORR_LANES] <= '0;
            end
            if (fresh_bank_i) begin
                clr_q[fresh_bank_sel_i] <= '1;
            end
        end
    end

    // ------------------------------------------------------------------
    // Bus read port, {bank, slot, lane, part}
    // ------------------------------------------------------------------
    assign rd_bank = read_addr_i[6:5];
    assign rd_slot = read_addr_i[4:3];
    assign rd_lane = read_addr_i[2:1];
    assign rd_part = corr_pkg::part_e'(read_addr_i[0]);

    always_ff @(posedge clk_x) begin
        if (read_ce_i) begin
            rd_word_q <= (rd_part == corr_pkg::part_re) ?
                         mem_re_q[rd_lane][{rd_bank, rd_slot}] :
                         mem_im_q[rd_lane][{rd_bank, rd_slot}];
        end
    end

    always_ff @(posedge clk_x or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_vld_q    <= 1'b0;
            read_data_o <= '0;
        end else begin
            rd_vld_q <= read_ce_i;
            if (rd_vld_q) begin
                read_data_o <= rd_word_q;     // Holds until the next read
            end
        end
    end

    // Slot spacing keeps the same word out of back-to-back writes
    a_no_raw: assert property (@(posedge clk_x) disable iff (!rst_n_i)
        wr_en_q |=> !(wr_en_q && (wr_addr_q == $past(wr_addr_q))));

endmodule

`default_nettype wire

// ==== hw/corr_cmul.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "corr_settings.svh"

module corr_cmul (
    input  logic                                         clk_x,
    input  logic                                         rst_n_i,
    input  logic                                         valid_i,
    input  logic        [`CORR_SLOT_W-1:0]               slot_i,
    input  logic        [`CORR_BANK_W-1:0]               bank_i,
    input  logic        [`CORR_LANES-1:0]                a_re_i,
    input  logic        [`CORR_LANES-1:0]                a_im_i,
    input  logic        [`CORR_LANES-1:0]                b_re_i,
    input  logic        [`CORR_LANES-1:0]                b_im_i,
    output logic                                         valid_o,
    output logic        [`CORR_SLOT_W-1:0]               slot_o,
    output logic        [`CORR_BANK_W-1:0]               bank_o,
    output logic signed [`CORR_LANES-1:0][`CORR_PROD_W-1:0] prod_re_o,
    output logic signed [`CORR_LANES-1:0][`CORR_PROD_W-1:0] prod_im_o
);

    localparam logic [`CORR_PROD_W-1:0] prod_pos = `CORR_PROD_W'(2);
    localparam logic [`CORR_PROD_W-1:0] prod_neg = `CORR_PROD_W'(-2);

    // Sign agreement gives +1, disagreement -1, so each half is a sum of two
    always_ff @(posedge clk_x) begin
        for (int l = 0; l < `CORR_LANES; l++) begin
            // Re: re_a*re_b + im_a*im_b
            case ({a_re_i[l] ~^ b_re_i[l], a_im_i[l] ~^ b_im_i[l]})
                2'b11:   prod_re_o[l] <= prod_pos;
                2'b00:   prod_re_o[l] <= prod_neg;
                default: prod_re_o[l] <= '0;
            endcase
            // Im: im_a*re_b - re_a*im_b
            case ({a_im_i[l] ~^ b_re_i[l], a_re_i[l] ~^ b_im_i[l]})
                2'b10:   prod_im_o[l] <= prod_pos;
                2'b01:   prod_im_o[l] <= prod_neg;
                default: prod_im_o[l] <= '0;
            endcase
        end
    end

    always_ff @(posedge clk_x or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
            slot_o  <= '0;
            bank_o  <= '0;
        end else begin
            valid_o <= valid_i;
            slot_o  <= slot_i;
            bank_o  <= bank_i;
        end
    end

endmodule

`default_nettype wire

// ==== hw/corr_control.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "corr_settings.svh"

module corr_control (
    input  logic                    clk_x,          // Correlator clock
    input  logic                    rst_n_i,
    input  logic                    en_i,           // Sample strobe
    input  logic                    sw_i,           // Bank switch strobe
    input  logic [`CORR_NANT-1:0]   re_i,
    input  logic [`CORR_NANT-1:0]   im_i,
    output logic [`CORR_SLOT_W-1:0] slot_o,
    output logic [`CORR_BANK_W-1:0] bank_o,         // Active bank
    output logic                    valid_o,
    output logic [`CORR_NANT-1:0]   re_o,           // Held samples
    output logic [`CORR_NANT-1:0]   im_o,
    output logic                    fresh_bank_o    // One cycle after switch
);

    corr_pkg::ctrl_state_e   state_q;
    logic [`CORR_SLOT_W-1:0] slot_q;
    logic [`CORR_BANK_W-1:0] bank_q;
    logic                    fresh_q;
    logic                    last_slot;
    logic                    ready;

    // Last slot overlaps with the next en_i, so 4-cycle spacing streams
    assign last_slot = (slot_q == `CORR_SLOT_W'(`CORR_SLOTS - 1));
    assign ready     = (state_q == corr_pkg::idle) || last_slot;

    // ------------------------------------------------------------------
    // Slot sequencer
    // ------------------------------------------------------------------
    always_ff @(posedge clk_x or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= corr_pkg::idle;
            slot_q  <= '0;
        end else begin
            case (state_q)
                corr_pkg::idle: begin
                    if (en_i) begin
                        state_q <= corr_pkg::busy;
                        slot_q  <= '0;
                    end
                end
                corr_pkg::busy: begin
                    slot_q <= slot_q + 1'b1;        // Wraps to slot 0
                    if (last_slot && !en_i) begin
                        state_q <= corr_pkg::idle;
                    end
                end
                default: state_q <= corr_pkg::idle;
            endcase
        end
    end

    // Bank pointer and clear pulse
    always_ff @(posedge clk_x or negedge rst_n_i) begin
        if (!rst_n_i) begin
            bank_q  <= '0;
            fresh_q <= 1'b0;
        end else begin
            fresh_q <= sw_i && ready;
            if (sw_i && ready) begin
                bank_q <= bank_q + 1'b1;            // Modulo 4
            end
        end
    end

    // Samples held for all four slots
    always_ff @(posedge clk_x) begin
        if (en_i && ready) begin
            re_o <= re_i;
            im_o <= im_i;
        end
    end

    assign slot_o       = slot_q;
    assign bank_o       = bank_q;
    assign valid_o      = (state_q == corr_pkg::busy);
    assign fresh_bank_o = fresh_q;

    a_en_ready: assert property (@(posedge clk_x) disable iff (!rst_n_i)
        en_i |-> ready);
    a_en_sw_excl: assert property (@(posedge clk_x) disable iff (!rst_n_i)
        !(en_i && sw_i));

endmodule

`default_nettype wire

// ==== hw/corr_pair_select.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "corr_settings.svh"

module corr_pair_select (
    input  logic                    clk_x,
    input  logic                    rst_n_i,
    input  logic                    valid_i,
    input  logic [`CORR_SLOT_W-1:0] slot_i,
    input  logic [`CORR_BANK_W-1:0] bank_i,
    input  logic [`CORR_NANT-1:0]   re_i,
    input  logic [`CORR_NANT-1:0]   im_i,
    output logic                    valid_o,
    output logic [`CORR_SLOT_W-1:0] slot_o,
    output logic [`CORR_BANK_W-1:0] bank_o,
    output logic [`CORR_LANES-1:0]  a_re_o,         // One bit per lane
    output logic [`CORR_LANES-1:0]  a_im_o,
    output logic [`CORR_LANES-1:0]  b_re_o,
    output logic [`CORR_LANES-1:0]  b_im_o
);

    logic [`CORR_ANT_W-1:0] ant_a [`CORR_LANES];
    logic [`CORR_ANT_W-1:0] ant_b [`CORR_LANES];

    // Table lookup for this slot's pairs
    always_comb begin
        for (int l = 0; l < `CORR_LANES; l++) begin
            ant_a[l] = corr_pkg::pair_ant_a[slot_i * `CORR_LANES + l];
            ant_b[l] = corr_pkg::pair_ant_b[slot_i * `CORR_LANES + l];
        end
    end

    always_ff @(posedge clk_x) begin
        for (int l = 0; l < `CORR_LANES; l++) begin
            a_re_o[l] <= re_i[ant_a[l]];
            a_im_o[l] <= im_i[ant_a[l]];
            b_re_o[l] <= re_i[ant_b[l]];
            b_im_o[l] <= im_i[ant_b[l]];
        end
    end

    // Control fields follow the data
    always_ff @(posedge clk_x or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
            slot_o  <= '0;
            bank_o  <= '0;
        end else begin
            valid_o <= valid_i;
            slot_o  <= slot_i;
            bank_o  <= bank_i;
        end
    end

endmodule

`default_nettype wire

// ==== hw/corr_pkg.sv ====
`default_nettype none
`include "corr_settings.svh"

package corr_pkg;

    // ------------------------------------------------------------------
    // Controller and accumulator selectors
    // ------------------------------------------------------------------
    typedef enum logic {
        idle,                           // Waiting for en_i
        busy                            // Issuing slots
    } ctrl_state_e;

    typedef enum logic {
        part_re,                        // Real half, addr bit 0 low
        part_im                         // Imag half
    } part_e;

    // ------------------------------------------------------------------
    // Fixed antenna pairs, pair p = slot*4 + lane
    // ------------------------------------------------------------------
    // Visibility is ant_a times conj(ant_b)
    localparam logic [`CORR_ANT_W-1:0] pair_ant_a [`CORR_PAIRS] = '{
        3'd0, 3'd0, 3'd0, 3'd0,         // Slot 0
        3'd1, 3'd1, 3'd1, 3'd1,         // Slot 1
        3'd2, 3'd2, 3'd2, 3'd3,         // Slot 2
        3'd4, 3'd5, 3'd6, 3'd7          // Slot 3
    };

    localparam logic [`CORR_ANT_W-1:0] pair_ant_b [`CORR_PAIRS] = '{
        3'd1, 3'd2, 3'd3, 3'd4,
        3'd2, 3'd3, 3'd4, 3'd5,
        3'd3, 3'd5, 3'd6, 3'd4,
        3'd5, 3'd6, 3'd7, 3'd0          // Wraps round the array
    };

endpackage

`default_nettype wire

// ==== hw/corr_settings.svh ====
`ifndef CORR_SETTINGS_SVH
`define CORR_SETTINGS_SVH

// ----------------------------------------------------------------------
// Antenna array and time multiplexing
// ----------------------------------------------------------------------
`define CORR_NANT       8       // Antennas, 1-bit re and im each
`define CORR_ANT_W      3       // Antenna index width
`define CORR_LANES      4       // Parallel multiplier lanes
`define CORR_LANE_W     2
`define CORR_SLOTS      4       // Time slots per sample
`define CORR_SLOT_W     2
`define CORR_PAIRS      16      // Lanes times slots

// ----------------------------------------------------------------------
// Visibility storage and readback
// ----------------------------------------------------------------------
`define CORR_BANKS      4       // Visibility banks
`define CORR_BANK_W     2
`define CORR_ACCUM      16      // Signed accumulator width
`define CORR_PROD_W     3       // Product is -2, 0 or +2

// Read address is {bank, pair, part}
`define CORR_ADDR_BITS  7
`define CORR_RD_LAT     2       // read_ce_i to read_data_o

`endif

// ==== hw/corr_top.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "corr_settings.svh"

module corr_top (
    input  logic                       clk_x,       // Correlator and bus clock
    input  logic                       rst_n_i,
    input  logic                       en_i,        // Sample strobe
    input  logic                       sw_i,        // Bank switch strobe
    input  logic [`CORR_NANT-1:0]      re_i,
    input  logic [`CORR_NANT-1:0]      im_i,
    output logic [`CORR_BANK_W-1:0]    bank_o,      // Bank being filled
    input  logic                       read_ce_i,
    input  logic [`CORR_ADDR_BITS-1:0] read_addr_i,
    output logic [`CORR_ACCUM-1:0]     read_data_o  // Two cycles after read_ce_i
);

    // Stage 1 to 2
    logic                    c_valid;
    logic [`CORR_SLOT_W-1:0] c_slot;
    logic [`CORR_BANK_W-1:0] c_bank;
    logic [`CORR_NANT-1:0]   c_re;
    logic [`CORR_NANT-1:0]   c_im;
    logic                    c_fresh;

    // Stage 2 to 3
    logic                    s_valid;
    logic [`CORR_SLOT_W-1:0] s_slot;
    logic [`CORR_BANK_W-1:0] s_bank;
    logic [`CORR_LANES-1:0]  s_a_re;
    logic [`CORR_LANES-1:0]  s_a_im;
    logic [`CORR_LANES-1:0]  s_b_re;
    logic [`CORR_LANES-1:0]  s_b_im;

    // Stage 3 to 4
    logic                    m_valid;
    logic [`CORR_SLOT_W-1:0] m_slot;
    logic [`CORR_BANK_W-1:0] m_bank;
    logic signed [`CORR_LANES-1:0][`CORR_PROD_W-1:0] m_prod_re;
    logic signed [`CORR_LANES-1:0][`CORR_PROD_W-1:0] m_prod_im;

    assign bank_o = c_bank;

    // ------------------------------------------------------------------
    // Four-stage correlator pipeline
    // ------------------------------------------------------------------
    corr_control i_corr_control (
        .clk_x(clk_x), .rst_n_i(rst_n_i),
        .en_i(en_i), .sw_i(sw_i), .re_i(re_i), .im_i(im_i),
        .slot_o(c_slot), .bank_o(c_bank), .valid_o(c_valid),
        .re_o(c_re), .im_o(c_im), .fresh_bank_o(c_fresh)
    );

    corr_pair_select i_corr_pair_select (
        .clk_x(clk_x), .rst_n_i(rst_n_i),
        .valid_i(c_valid), .slot_i(c_slot), .bank_i(c_bank),
        .re_i(c_re), .im_i(c_im),
        .valid_o(s_valid), .slot_o(s_slot), .bank_o(s_bank),
        .a_re_o(s_a_re), .a_im_o(s_a_im), .b_re_o(s_b_re), .b_im_o(s_b_im)
    );

    corr_cmul i_corr_cmul (
        .clk_x(clk_x), .rst_n_i(rst_n_i),
        .valid_i(s_valid), .slot_i(s_slot), .bank_i(s_bank),
        .a_re_i(s_a_re), .a_im_i(s_a_im), .b_re_i(s_b_re), .b_im_i(s_b_im),
        .valid_o(m_valid), .slot_o(m_slot), .bank_o(m_bank),
        .prod_re_o(m_prod_re), .prod_im_o(m_prod_im)
    );

    // Clear logic takes the live bank, not the pipelined one
    corr_accum i_corr_accum (
        .clk_x(clk_x), .rst_n_i(rst_n_i),
        .valid_i(m_valid), .slot_i(m_slot), .bank_i(m_bank),
        .prod_re_i(m_prod_re), .prod_im_i(m_prod_im),
        .fresh_bank_i(c_fresh), .fresh_bank_sel_i(c_bank),
        .read_ce_i(read_ce_i), .read_addr_i(read_addr_i),
        .read_data_o(read_data_o)
    );

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+hw
hw/corr_pkg.sv
hw/corr_control.sv
hw/corr_pair_select.sv
hw/corr_cmul.sv
hw/corr_accum.sv
hw/corr_top.sv
tests/corr_checker.sv
tests/tb_corr_top.sv

// ==== tests/corr_checker.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "corr_settings.svh"

module corr_checker (
    input  logic                       clk_x,
    input  logic                       rst_n_i,
    input  logic                       en_i,        // Mirrored DUT strobes
    input  logic                       sw_i,
    input  logic [`CORR_NANT-1:0]      re_i,
    input  logic [`CORR_NANT-1:0]      im_i,
    input  logic [`CORR_BANK_W-1:0]    bank_i,      // DUT bank_o
    input  logic                       read_ce_i,
    input  logic [`CORR_ADDR_BITS-1:0] read_addr_i,
    input  logic [`CORR_ACCUM-1:0]     read_data_i, // DUT read_data_o
    output int                         checks_o,
    output int                         errors_o
);

    int                      model_re [`CORR_BANKS][`CORR_PAIRS];
    int                      model_im [`CORR_BANKS][`CORR_PAIRS];
    logic [`CORR_BANK_W-1:0] bank_m;                // Model of the active bank

    // Read pipeline, one entry per cycle of latency
    logic                        d1_vld;
    logic                        d2_vld;
    logic [`CORR_ACCUM-1:0]      d1_exp;
    logic [`CORR_ACCUM-1:0]      d2_exp;
    logic [`CORR_ADDR_BITS-1:0]  d1_addr;
    logic [`CORR_ADDR_BITS-1:0]  d2_addr;
    logic [`CORR_ACCUM-1:0]      last_data;         // Value read_data_o must hold

    // Bit 1 stands for +1, bit 0 for -1
    function automatic int sign_of(input logic b);
        return b ? 1 : -1;
    endfunction

    // Address is {bank, pair, part}
    function automatic logic [`CORR_ACCUM-1:0] expected_word(
        input logic [`CORR_ADDR_BITS-1:0] addr);
        int bank;
        int pair;
        bank = int'(addr[6:5]);
        pair = int'(addr[4:1]);
        if (addr[0]) begin
            return `CORR_ACCUM'(model_im[bank][pair]);
        end
        return `CORR_ACCUM'(model_re[bank][pair]);
    endfunction

    // ------------------------------------------------------------------
    // Reference model, a times conj(b) for every pair
    // ------------------------------------------------------------------
    task automatic add_sample(input logic [`CORR_NANT-1:0] re,
                              input logic [`CORR_NANT-1:0] im);
        int ar;
        int ai;
        int br;
        int bi;
        for (int p = 0; p < `CORR_PAIRS; p++) begin
            ar = sign_of(re[corr_pkg::pair_ant_a[p]]);
            ai = sign_of(im[corr_pkg::pair_ant_a[p]]);
            br = sign_of(re[corr_pkg::pair_ant_b[p]]);
            bi = sign_of(im[corr_pkg::pair_ant_b[p]]);
            model_re[bank_m][p] += ar * br + ai * bi;   // Re(a) Re(b) + Im(a) Im(b)
            model_im[bank_m][p] += ai * br - ar * bi;
        end
    endtask

    task automatic report_error(input string sig, input logic [`CORR_ACCUM-1:0] exp_v,
                                input logic [`CORR_ACCUM-1:0] got_v);
        errors_o++;
        $display("mismatch at %0t ns: %s expected %h got %h", $time, sig, exp_v, got_v);
    endtask

    always @(posedge clk_x or negedge rst_n_i) begin
        if (!rst_n_i) begin
            bank_m    = '0;
            d1_vld    = 1'b0;
            d2_vld    = 1'b0;
            last_data = '0;
            for (int b = 0; b < `CORR_BANKS; b++) begin
                for (int p = 0; p < `CORR_PAIRS; p++) begin
                    model_re[b][p] = 0;
                    model_im[b][p] = 0;
                end
            end
        end else begin
            checks_o++;
            if (bank_i !== bank_m) begin
                report_error("bank_o", `CORR_ACCUM'(bank_m), `CORR_ACCUM'(bank_i));
            end
            // Data due two edges after its read_ce_i, else it must hold
            checks_o++;
            if (d2_vld) begin
                if (read_data_i !== d2_exp) begin
                    report_error($sformatf("read_data_o[addr %h]", d2_addr),
                                 d2_exp, read_data_i);
                end
            end else if (read_data_i !== last_data) begin
                report_error("read_data_o held", last_data, read_data_i);
            end
            if (d2_vld) begin
                last_data = d2_exp;             // Word held until the next read
            end
            d2_vld  = d1_vld;
            d2_exp  = d1_exp;
            d2_addr = d1_addr;
            d1_vld  = read_ce_i;
            d1_exp  = expected_word(read_addr_i);
            d1_addr = read_addr_i;
            if (en_i) begin
                add_sample(re_i, im_i);
            end
            if (sw_i) begin
                bank_m = bank_m + 1'b1;         // Modulo 4
                for (int p = 0; p < `CORR_PAIRS; p++) begin
                    model_re[bank_m][p] = 0;    // New bank starts clean
                    model_im[bank_m][p] = 0;
                end
            end
        end
    end

    initial begin
        checks_o = 0;
        errors_o = 0;
    end

endmodule

`default_nettype wire

// ==== tests/tb_corr_top.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "corr_settings.svh"

module tb_corr_top;

    localparam int n_rand       = 200;      // Test 2 samples
    localparam int n_fill       = 10;       // Per bank in test 3
    localparam int n_burst      = 20;       // Test 4 samples
    localparam int n_reads      = 100;      // Test 5 reads
    localparam int gap_max      = 7;
    localparam int wide_gap     = 10;
    localparam int read_gap_max = 3;
    localparam int drain        = 10;       // Pipeline flush, more than 8
    localparam int bank_words   = 1 << (`CORR_ADDR_BITS - `CORR_BANK_W);
    localparam int read_cycles  = bank_words * (read_gap_max + 1) + 8;
    localparam int stim_cycles  = (n_rand + 3 * n_fill + 1) * gap_max
                                + n_burst * (4 + wide_gap) + 20 * drain
                                + 7 * read_cycles + n_reads * 6 + 40;
    localparam int cycle_limit  = 2 * stim_cycles;

    logic                       clk_x;
    logic                       rst_n_i;
    logic                       en_i;
    logic                       sw_i;
    logic [`CORR_NANT-1:0]      re_i;
    logic [`CORR_NANT-1:0]      im_i;
    logic [`CORR_BANK_W-1:0]    bank_o;
    logic                       read_ce_i;
    logic [`CORR_ADDR_BITS-1:0] read_addr_i;
    logic [`CORR_ACCUM-1:0]     read_data_o;

    int checks;
    int errors;
    int prev_checks;
    int prev_errors;
    int tests_run;
    int tests_failed;
    int cycle_cnt;
    logic [`CORR_NANT-1:0] burst_re [n_burst];
    logic [`CORR_NANT-1:0] burst_im [n_burst];

    corr_top i_corr_top (
        .clk_x(clk_x), .rst_n_i(rst_n_i), .en_i(en_i), .sw_i(sw_i),
        .re_i(re_i), .im_i(im_i), .bank_o(bank_o),
        .read_ce_i(read_ce_i), .read_addr_i(read_addr_i), .read_data_o(read_data_o)
    );

    corr_checker i_corr_checker (
        .clk_x(clk_x), .rst_n_i(rst_n_i), .en_i(en_i), .sw_i(sw_i),
        .re_i(re_i), .im_i(im_i), .bank_i(bank_o),
        .read_ce_i(read_ce_i), .read_addr_i(read_addr_i), .read_data_i(read_data_o),
        .checks_o(checks), .errors_o(errors)
    );

    initial begin
        clk_x = 1'b0;
        forever #20 clk_x = ~clk_x;             // 40 ns period
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk_x);
            cycle_cnt++;
        end
        $display("timeout: run did not finish within %0d cycles", cycle_limit);
        $display("CHECKS FAILED");
        $finish;
    end

    // ------------------------------------------------------------------
    // Stimulus tasks, all entered and left on a falling edge
    // ------------------------------------------------------------------
    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clk_x);
    endtask

    // Gap of 4 is back to back
    task automatic send_sample(input logic [`CORR_NANT-1:0] re,
                               input logic [`CORR_NANT-1:0] im, input int gap);
        en_i = 1'b1;
        re_i = re;
        im_i = im;
        @(negedge clk_x);
        en_i = 1'b0;
        idle_cycles(gap - 1);
    endtask

    task automatic fill_random(input int n);
        repeat (n) send_sample(`CORR_NANT'($urandom), `CORR_NANT'($urandom),
                               $urandom_range(gap_max, 4));
        idle_cycles(drain);
    endtask

    task automatic switch_bank();
        sw_i = 1'b1;
        @(negedge clk_x);
        sw_i = 1'b0;
        idle_cycles(drain);
    endtask

    task automatic read_word(input logic [`CORR_ADDR_BITS-1:0] addr, input int gap);
        read_ce_i   = 1'b1;
        read_addr_i = addr;
        @(negedge clk_x);
        read_ce_i = 1'b0;
        idle_cycles(gap);
    endtask

    task automatic read_bank(input logic [`CORR_BANK_W-1:0] bank);
        for (int a = 0; a < bank_words; a++) begin
            read_word({bank, 5'(a)}, $urandom_range(read_gap_max, 0));
        end
        idle_cycles(4);
    endtask

    task automatic finish_test(input string name);
        idle_cycles(4);                         // Last read compared
        tests_run++;
        if (errors > prev_errors) begin
            tests_failed++;
        end
        $display("test %0d %s: %0d checks, %0d errors", tests_run, name,
                 checks - prev_checks, errors - prev_errors);
        prev_checks = checks;
        prev_errors = errors;
    endtask

    initial begin
        void'($urandom(78435));
        rst_n_i      = 1'b0;
        en_i         = 1'b0;
        sw_i         = 1'b0;
        re_i         = '0;
        im_i         = '0;
        read_ce_i    = 1'b0;
        read_addr_i  = '0;
        prev_checks  = 0;
        prev_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (2) @(posedge clk_x);
        @(negedge clk_x);
        rst_n_i = 1'b1;
        idle_cycles(2);

        // All antennas at +1 into bank 0
        send_sample('1, '1, 4);
        idle_cycles(drain);
        switch_bank();
        read_bank(2'd0);
        finish_test("reset and unit sample");

        fill_random(n_rand);                    // Bank 1
        switch_bank();
        read_bank(2'd1);
        finish_test("random accumulate");

        // Banks 2 and 3, then bank 0 is filled a second time
        fill_random(n_fill);
        switch_bank();
        fill_random(n_fill);
        switch_bank();
        fill_random(n_fill);
        switch_bank();
        read_bank(2'd0);
        read_bank(2'd2);
        read_bank(2'd3);
        finish_test("bank switch and clear");

        // Same samples streamed into bank 1 and spread out into bank 2
        for (int i = 0; i < n_burst; i++) begin
            burst_re[i] = `CORR_NANT'($urandom);
            burst_im[i] = `CORR_NANT'($urandom);
        end
        for (int i = 0; i < n_burst; i++) send_sample(burst_re[i], burst_im[i], 4);
        idle_cycles(drain);
        switch_bank();
        for (int i = 0; i < n_burst; i++) send_sample(burst_re[i], burst_im[i], wide_gap);
        idle_cycles(drain);
        switch_bank();
        read_bank(2'd1);
        read_bank(2'd2);
        finish_test("back-to-back samples");

        // Bank 3 is active, banks 0 to 2 hold data
        repeat (n_reads) begin
            read_word({2'($urandom_range(2, 0)), 5'($urandom)}, $urandom_range(5, 0));
        end
        finish_test("random reads");

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
